// File: dispatchPkg.sv
/* Dispatch stage package
   Shared widths, queue-size defaults and the packet formats that travel
   from rename into the issue queue, active list and load-store queue */

package dispatchPkg;

  // Core widths
  localparam int CheckpointsW  = 8;   // Branch checkpoints, one mask bit each
  localparam int CheckpointIdW = 3;   // Index into the checkpoint table
  localparam int PhysRegW      = 7;   // Physical register tag
  localparam int ArchRegW      = 5;   // Architectural register from the map table
  localparam int PcW           = 32;
  localparam int ImmW          = 16;
  localparam int OpcodeW       = 8;
  localparam int CtiIdW        = 4;   // Control-transfer table index

  // Default configuration of the back end
  localparam int DefaultDispatchWidth  = 4;
  localparam int DefaultLsqSize        = 16;  // Each of load queue and store queue
  localparam int DefaultIssueQSize     = 32;
  localparam int DefaultActiveListSize = 64;

  // One instruction as it leaves rename
  typedef struct packed {
    logic [ArchRegW-1:0]      archDest;
    logic                     destValid;
    logic                     isStore;
    logic                     isLoad;
    logic [CheckpointsW-1:0]  branchMask;    // Unresolved branches this one depends on
    logic [CheckpointIdW-1:0] checkpointId;
    logic [PhysRegW-1:0]      srcAPhys;
    logic [PhysRegW-1:0]      srcBPhys;
    logic [PhysRegW-1:0]      physDest;
    logic [PhysRegW-1:0]      oldPhysDest;   // Freed when this instruction retires
    logic                     srcAValid;
    logic                     srcBValid;
    logic [ImmW-1:0]          imm;
    logic [OpcodeW-1:0]       opcode;
    logic [PcW-1:0]           pc;
    logic [PcW-1:0]           nextPc;
    logic [CtiIdW-1:0]        ctiId;
  } renamedPktT;

  // Issue queue entry, everything but the architectural destination
  typedef struct packed {
    logic                     destValid;
    logic                     isStore;
    logic                     isLoad;
    logic [CheckpointsW-1:0]  branchMask;
    logic [CheckpointIdW-1:0] checkpointId;
    logic [PhysRegW-1:0]      srcAPhys;
    logic [PhysRegW-1:0]      srcBPhys;
    logic [PhysRegW-1:0]      physDest;
    logic [PhysRegW-1:0]      oldPhysDest;
    logic                     srcAValid;
    logic                     srcBValid;
    logic [ImmW-1:0]          imm;
    logic [OpcodeW-1:0]       opcode;
    logic [PcW-1:0]           pc;
    logic [PcW-1:0]           nextPc;
    logic [CtiIdW-1:0]        ctiId;
  } iqPktT;

  // Active list entry, only what retirement needs
  typedef struct packed {
    logic                isLoad;
    logic                isStore;
    logic [PcW-1:0]      pc;
    logic [ArchRegW-1:0] archDest;
    logic [PhysRegW-1:0] physDest;
    logic [PhysRegW-1:0] oldPhysDest;
    logic                destValid;
  } alPktT;

  // Load-store queue entry
  typedef struct packed {
    logic [CheckpointsW-1:0] branchMask;   // Needed to squash on a mispredict
    logic                    isStore;
    logic                    isLoad;
  } lsqPktT;

endpackage

// File: dispatchDecode.sv
/* Dispatch decode
   Clears the verified checkpoint bit from every lane's branch mask and
   counts the loads and stores in the incoming group */

`timescale 1ns/10ps

module dispatchDecode #(
  parameter int DispatchWidth = dispatchPkg::DefaultDispatchWidth,
  localparam int CntW = $clog2(DispatchWidth + 1)
) (
  input  logic                                   clk,
  input  logic                                   arstN_i,
  input  dispatchPkg::renamedPktT [DispatchWidth-1:0] renamedPkt_i,
  input  logic                                   ctrlVerified_i,
  input  logic [dispatchPkg::CheckpointIdW-1:0]  ctrlVerifiedId_i,
  output dispatchPkg::renamedPktT [DispatchWidth-1:0] decodedPkt_o,
  output logic [DispatchWidth-1:0][dispatchPkg::CheckpointsW-1:0] updatedBranchMask_o,
  output logic [CntW-1:0]                        loadCnt_o,
  output logic [CntW-1:0]                        storeCnt_o
);

  logic [dispatchPkg::CheckpointsW-1:0] clrMask;   // One-hot bit of the resolved branch
  logic [DispatchWidth-1:0]             bothLdSt;  // Lanes marked as load and store at once

  assign clrMask = ctrlVerified_i ?
                   dispatchPkg::CheckpointsW'(1) << ctrlVerifiedId_i :
                   '0;

  // Mask update applies to every lane, stalled or not,
  // so the group waiting in front of dispatch stays current
  always_comb begin
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      decodedPkt_o[lane]            = renamedPkt_i[lane];
      decodedPkt_o[lane].branchMask = renamedPkt_i[lane].branchMask & ~clrMask;
      updatedBranchMask_o[lane]     = decodedPkt_o[lane].branchMask;
    end
  end

  // True sums over all lanes
  always_comb begin
    loadCnt_o  = '0;
    storeCnt_o = '0;
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      loadCnt_o  = loadCnt_o + CntW'(renamedPkt_i[lane].isLoad);
      storeCnt_o = storeCnt_o + CntW'(renamedPkt_i[lane].isStore);
    end
  end

  always_comb begin
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      bothLdSt[lane] = renamedPkt_i[lane].isLoad & renamedPkt_i[lane].isStore;
    end
  end

  // Rename never sends an instruction that is both a load and a store
  assert property (@(posedge clk) disable iff (!arstN_i)
    bothLdSt == '0)
    else $error("dispatchDecode: lanes %b marked both load and store", bothLdSt);

endmodule

// File: dispatchCapacity.sv
/* Dispatch capacity check
   Compares back-end occupancy plus the incoming group against each
   structure's size and raises the front-end stall */

`timescale 1ns/10ps

module dispatchCapacity #(
  parameter int DispatchWidth  = dispatchPkg::DefaultDispatchWidth,
  parameter int LsqSize        = dispatchPkg::DefaultLsqSize,
  parameter int IssueQSize     = dispatchPkg::DefaultIssueQSize,
  parameter int ActiveListSize = dispatchPkg::DefaultActiveListSize,
  localparam int CntW   = $clog2(DispatchWidth + 1),
  localparam int LsqCntW = $clog2(LsqSize + 1),
  localparam int IqCntW  = $clog2(IssueQSize + 1),
  localparam int AlCntW  = $clog2(ActiveListSize + 1)
) (
  input  logic               clk,
  input  logic               arstN_i,
  input  logic [CntW-1:0]    loadCnt_i,
  input  logic [CntW-1:0]    storeCnt_i,
  input  logic [LsqCntW-1:0] loadQueueCnt_i,
  input  logic [LsqCntW-1:0] storeQueueCnt_i,
  input  logic [IqCntW-1:0]  issueQueueCnt_i,
  input  logic [AlCntW-1:0]  activeListCnt_i,
  input  logic               renameReady_i,
  input  logic               flagRecover_i,
  output logic               backEndReady_o,
  output logic               stallFrontEnd_o
);

  // One extra bit on every sum so the compare never wraps
  localparam int LsqSumW = (LsqCntW > CntW ? LsqCntW : CntW) + 1;
  localparam int IqSumW  = IqCntW + CntW + 1;
  localparam int AlSumW  = AlCntW + CntW + 1;

  logic [LsqSumW-1:0] loadSum;
  logic [LsqSumW-1:0] storeSum;
  logic [IqSumW-1:0]  iqSum;
  logic [AlSumW-1:0]  alSum;
  logic [3:0]         overflow;   // Load, store, issue queue, active list

  assign loadSum  = LsqSumW'(loadQueueCnt_i) + LsqSumW'(loadCnt_i);
  assign storeSum = LsqSumW'(storeQueueCnt_i) + LsqSumW'(storeCnt_i);
  assign iqSum    = IqSumW'(issueQueueCnt_i) + IqSumW'(DispatchWidth);   // Whole group reserved
  assign alSum    = AlSumW'(activeListCnt_i) + AlSumW'(DispatchWidth);

  assign overflow[0] = loadSum > LsqSumW'(LsqSize);
  assign overflow[1] = storeSum > LsqSumW'(LsqSize);
  assign overflow[2] = iqSum > IqSumW'(IssueQSize);
  assign overflow[3] = alSum > AlSumW'(ActiveListSize);

  assign stallFrontEnd_o = |overflow;
  assign backEndReady_o  = renameReady_i & ~stallFrontEnd_o & ~flagRecover_i;

  // Back-end structures never report more entries than they hold
  assert property (@(posedge clk) disable iff (!arstN_i)
    (loadQueueCnt_i <= LsqSize) && (storeQueueCnt_i <= LsqSize) &&
    (issueQueueCnt_i <= IssueQSize) && (activeListCnt_i <= ActiveListSize))
    else $error("dispatchCapacity: occupancy count above queue size");

endmodule

// File: dispatchResult.sv
/* Dispatch result stage
   Builds issue-queue, active-list and load-store packets per lane and
   holds them in the pipeline register toward the back end */

`timescale 1ns/10ps

module dispatchResult #(
  parameter int DispatchWidth = dispatchPkg::DefaultDispatchWidth
) (
  input  logic                                        clk,
  input  logic                                        arstN_i,
  input  dispatchPkg::renamedPktT [DispatchWidth-1:0] decodedPkt_i,
  input  logic                                        backEndReady_i,
  output dispatchPkg::iqPktT      [DispatchWidth-1:0] iqPkt_o,
  output dispatchPkg::alPktT      [DispatchWidth-1:0] alPkt_o,
  output dispatchPkg::lsqPktT     [DispatchWidth-1:0] lsqPkt_o,
  output logic                                        dispatchValid_o
);

  dispatchPkg::iqPktT  [DispatchWidth-1:0] iqNext;
  dispatchPkg::alPktT  [DispatchWidth-1:0] alNext;
  dispatchPkg::lsqPktT [DispatchWidth-1:0] lsqNext;

  always_comb begin
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      // Issue queue gets the full instruction minus archDest
      iqNext[lane].destValid    = decodedPkt_i[lane].destValid;
      iqNext[lane].isStore      = decodedPkt_i[lane].isStore;
      iqNext[lane].isLoad       = decodedPkt_i[lane].isLoad;
      iqNext[lane].branchMask   = decodedPkt_i[lane].branchMask;
      iqNext[lane].checkpointId = decodedPkt_i[lane].checkpointId;
      iqNext[lane].srcAPhys     = decodedPkt_i[lane].srcAPhys;
      iqNext[lane].srcBPhys     = decodedPkt_i[lane].srcBPhys;
      iqNext[lane].physDest     = decodedPkt_i[lane].physDest;
      iqNext[lane].oldPhysDest  = decodedPkt_i[lane].oldPhysDest;
      iqNext[lane].srcAValid    = decodedPkt_i[lane].srcAValid;
      iqNext[lane].srcBValid    = decodedPkt_i[lane].srcBValid;
      iqNext[lane].imm          = decodedPkt_i[lane].imm;
      iqNext[lane].opcode       = decodedPkt_i[lane].opcode;
      iqNext[lane].pc           = decodedPkt_i[lane].pc;
      iqNext[lane].nextPc       = decodedPkt_i[lane].nextPc;
      iqNext[lane].ctiId        = decodedPkt_i[lane].ctiId;

      alNext[lane].isLoad       = decodedPkt_i[lane].isLoad;
      alNext[lane].isStore      = decodedPkt_i[lane].isStore;
      alNext[lane].pc           = decodedPkt_i[lane].pc;
      alNext[lane].archDest     = decodedPkt_i[lane].archDest;
      alNext[lane].physDest     = decodedPkt_i[lane].physDest;
      alNext[lane].oldPhysDest  = decodedPkt_i[lane].oldPhysDest;   // Freed at retire
      alNext[lane].destValid    = decodedPkt_i[lane].destValid;

      lsqNext[lane].branchMask  = decodedPkt_i[lane].branchMask;
      lsqNext[lane].isStore     = decodedPkt_i[lane].isStore;
      lsqNext[lane].isLoad      = decodedPkt_i[lane].isLoad;
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      dispatchValid_o <= 1'b0;
      iqPkt_o         <= '0;
      alPkt_o         <= '0;
      lsqPkt_o        <= '0;
    end else begin
      dispatchValid_o <= backEndReady_i;   // Drops for one cycle on any stall
      if (backEndReady_i) begin
        iqPkt_o  <= iqNext;
        alPkt_o  <= alNext;
        lsqPkt_o <= lsqNext;
      end
    end
  end

  // An accepted group carries no unknown bits into the back end
  assert property (@(posedge clk) disable iff (!arstN_i)
    backEndReady_i |-> !$isunknown(decodedPkt_i))
    else $error("dispatchResult: unknown bits in an accepted group");

endmodule

// File: dispatch.sv
/* Dispatch stage top
   Four-wide dispatch of a renamed group into issue queue, active list
   and load-store queue, with a capacity check and one output register */

`timescale 1ns/10ps

module dispatch #(
  parameter int DispatchWidth  = dispatchPkg::DefaultDispatchWidth,
  parameter int LsqSize        = dispatchPkg::DefaultLsqSize,
  parameter int IssueQSize     = dispatchPkg::DefaultIssueQSize,
  parameter int ActiveListSize = dispatchPkg::DefaultActiveListSize
) (
  input  logic                                        clk,
  input  logic                                        arstN_i,
  input  dispatchPkg::renamedPktT [DispatchWidth-1:0] renamedPkt_i,
  input  logic                                        renameReady_i,   // Group present
  input  logic                                        flagRecover_i,
  input  logic                                        ctrlVerified_i,
  input  logic [dispatchPkg::CheckpointIdW-1:0]       ctrlVerifiedId_i,
  input  logic [$clog2(LsqSize+1)-1:0]                loadQueueCnt_i,
  input  logic [$clog2(LsqSize+1)-1:0]                storeQueueCnt_i,
  input  logic [$clog2(IssueQSize+1)-1:0]             issueQueueCnt_i,
  input  logic [$clog2(ActiveListSize+1)-1:0]         activeListCnt_i,
  output dispatchPkg::iqPktT      [DispatchWidth-1:0] iqPkt_o,
  output dispatchPkg::alPktT      [DispatchWidth-1:0] alPkt_o,
  output dispatchPkg::lsqPktT     [DispatchWidth-1:0] lsqPkt_o,
  output logic                                        dispatchValid_o,
  output logic [DispatchWidth-1:0][dispatchPkg::CheckpointsW-1:0] updatedBranchMask_o,
  output logic                                        backEndReady_o,
  output logic                                        stallFrontEnd_o
);

  localparam int CntW = $clog2(DispatchWidth + 1);

  dispatchPkg::renamedPktT [DispatchWidth-1:0] decodedPkt;
  logic [CntW-1:0] loadCnt;
  logic [CntW-1:0] storeCnt;

  dispatchDecode #(
    .DispatchWidth       (DispatchWidth)
  ) uDecode (
    .clk                 (clk),
    .arstN_i             (arstN_i),
    .renamedPkt_i        (renamedPkt_i),
    .ctrlVerified_i      (ctrlVerified_i),
    .ctrlVerifiedId_i    (ctrlVerifiedId_i),
    .decodedPkt_o        (decodedPkt),
    .updatedBranchMask_o (updatedBranchMask_o),   // Back to the rename/dispatch register
    .loadCnt_o           (loadCnt),
    .storeCnt_o          (storeCnt)
  );

  dispatchCapacity #(
    .DispatchWidth   (DispatchWidth),
    .LsqSize         (LsqSize),
    .IssueQSize      (IssueQSize),
    .ActiveListSize  (ActiveListSize)
  ) uCapacity (
    .clk             (clk),
    .arstN_i         (arstN_i),
    .loadCnt_i       (loadCnt),
    .storeCnt_i      (storeCnt),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .renameReady_i   (renameReady_i),
    .flagRecover_i   (flagRecover_i),
    .backEndReady_o  (backEndReady_o),
    .stallFrontEnd_o (stallFrontEnd_o)
  );

  dispatchResult #(
    .DispatchWidth   (DispatchWidth)
  ) uResult (
    .clk             (clk),
    .arstN_i         (arstN_i),
    .decodedPkt_i    (decodedPkt),
    .backEndReady_i  (backEndReady_o),
    .iqPkt_o         (iqPkt_o),
    .alPkt_o         (alPkt_o),
    .lsqPkt_o        (lsqPkt_o),
    .dispatchValid_o (dispatchValid_o)
  );

endmodule

// File: tbDispatch.sv
/* Dispatch stage testbench
   Random groups through the four-wide dispatch stage, checked by concurrent
   assertions against a reference built from the stage's flow rules */

`timescale 1ns/10ps

module tbDispatch;

  localparam int DispatchWidth  = dispatchPkg::DefaultDispatchWidth;
  localparam int LsqSize        = dispatchPkg::DefaultLsqSize;
  localparam int IssueQSize     = dispatchPkg::DefaultIssueQSize;
  localparam int ActiveListSize = dispatchPkg::DefaultActiveListSize;
  localparam int LsqCntW        = $clog2(LsqSize + 1);
  localparam int IqCntW         = $clog2(IssueQSize + 1);
  localparam int AlCntW         = $clog2(ActiveListSize + 1);
  localparam int NumTests       = 6;
  localparam int CyclesPerTest  = 64;   // Longest test stays below this
  localparam int Timeout        = NumTests * CyclesPerTest * 20 + 1000;

  logic clk = 1'b0;
  logic arstN_i;
  dispatchPkg::renamedPktT [DispatchWidth-1:0] renamedPkt_i;
  logic renameReady_i;
  logic flagRecover_i;
  logic ctrlVerified_i;
  logic [dispatchPkg::CheckpointIdW-1:0] ctrlVerifiedId_i;
  logic [LsqCntW-1:0] loadQueueCnt_i;
  logic [LsqCntW-1:0] storeQueueCnt_i;
  logic [IqCntW-1:0]  issueQueueCnt_i;
  logic [AlCntW-1:0]  activeListCnt_i;
  dispatchPkg::iqPktT  [DispatchWidth-1:0] iqPkt_o;
  dispatchPkg::alPktT  [DispatchWidth-1:0] alPkt_o;
  dispatchPkg::lsqPktT [DispatchWidth-1:0] lsqPkt_o;
  logic dispatchValid_o;
  logic [DispatchWidth-1:0][dispatchPkg::CheckpointsW-1:0] updatedBranchMask_o;
  logic backEndReady_o;
  logic stallFrontEnd_o;

  // Reference model state
  logic [DispatchWidth-1:0][dispatchPkg::CheckpointsW-1:0] expMask;
  logic expStall;
  logic expReady;
  logic expValid;
  int   loads;
  int   stores;
  dispatchPkg::iqPktT  [DispatchWidth-1:0] nextIq;
  dispatchPkg::alPktT  [DispatchWidth-1:0] nextAl;
  dispatchPkg::lsqPktT [DispatchWidth-1:0] nextLsq;
  dispatchPkg::iqPktT  [DispatchWidth-1:0] expIq;
  dispatchPkg::alPktT  [DispatchWidth-1:0] expAl;
  dispatchPkg::lsqPktT [DispatchWidth-1:0] expLsq;

  logic [31:0] seed = 32'h2f3d;
  int errCount    = 0;
  int testsRun    = 0;
  int testsPassed = 0;
  int cycleCnt    = 0;

  dispatch UUT (
    .clk                 (clk),
    .arstN_i             (arstN_i),
    .renamedPkt_i        (renamedPkt_i),
    .renameReady_i       (renameReady_i),
    .flagRecover_i       (flagRecover_i),
    .ctrlVerified_i      (ctrlVerified_i),
    .ctrlVerifiedId_i    (ctrlVerifiedId_i),
    .loadQueueCnt_i      (loadQueueCnt_i),
    .storeQueueCnt_i     (storeQueueCnt_i),
    .issueQueueCnt_i     (issueQueueCnt_i),
    .activeListCnt_i     (activeListCnt_i),
    .iqPkt_o             (iqPkt_o),
    .alPkt_o             (alPkt_o),
    .lsqPkt_o            (lsqPkt_o),
    .dispatchValid_o     (dispatchValid_o),
    .updatedBranchMask_o (updatedBranchMask_o),
    .backEndReady_o      (backEndReady_o),
    .stallFrontEnd_o     (stallFrontEnd_o)
  );

  always #10 clk = ~clk;   // 20 ns period

  always @(posedge clk) cycleCnt <= cycleCnt + 1;

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic int randRange(input int lo, input int hi);
    logic [31:0] r;
    r = nextRand() >> 16;   // Upper bits, the low ones cycle quickly
    return lo + int'(r) % (hi - lo + 1);
  endfunction

  function automatic dispatchPkg::renamedPktT randomPkt();
    dispatchPkg::renamedPktT p;
    logic [31:0] r;
    r = nextRand();
    p.archDest     = r[16 +: dispatchPkg::ArchRegW];
    p.destValid    = r[21];
    p.isLoad       = r[22];
    p.isStore      = !r[22] && r[23];   // Never both
    p.branchMask   = r[24 +: dispatchPkg::CheckpointsW];
    r = nextRand();
    p.checkpointId = r[16 +: dispatchPkg::CheckpointIdW];
    p.srcAPhys     = r[19 +: dispatchPkg::PhysRegW];
    p.srcAValid    = r[26];
    p.srcBValid    = r[27];
    p.ctiId        = r[28 +: dispatchPkg::CtiIdW];
    r = nextRand();
    p.srcBPhys     = r[16 +: dispatchPkg::PhysRegW];
    p.physDest     = r[23 +: dispatchPkg::PhysRegW];
    r = nextRand();
    p.oldPhysDest  = r[16 +: dispatchPkg::PhysRegW];
    p.opcode       = r[23 +: dispatchPkg::OpcodeW];
    r = nextRand();
    p.imm          = r[16 +: dispatchPkg::ImmW];
    p.pc           = nextRand();
    p.nextPc       = p.pc + 32'd4;
    return p;
  endfunction

  // Issue queue takes every renamed field except archDest
  function automatic dispatchPkg::iqPktT iqFromGroup(input dispatchPkg::renamedPktT p,
                                                      input logic [7:0] mask);
    dispatchPkg::iqPktT q;
    q.destValid    = p.destValid;
    q.isStore      = p.isStore;
    q.isLoad       = p.isLoad;
    q.branchMask   = mask;
    q.checkpointId = p.checkpointId;
    q.srcAPhys     = p.srcAPhys;
    q.srcBPhys     = p.srcBPhys;
    q.physDest     = p.physDest;
    q.oldPhysDest  = p.oldPhysDest;
    q.srcAValid    = p.srcAValid;
    q.srcBValid    = p.srcBValid;
    q.imm          = p.imm;
    q.opcode       = p.opcode;
    q.pc           = p.pc;
    q.nextPc       = p.nextPc;
    q.ctiId        = p.ctiId;
    return q;
  endfunction

  // Flow rules evaluated on the current inputs
  always_comb begin
    loads  = 0;
    stores = 0;
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      if (renamedPkt_i[lane].isLoad) loads++;
      if (renamedPkt_i[lane].isStore) stores++;
      for (int b = 0; b < dispatchPkg::CheckpointsW; b++) begin
        expMask[lane][b] = renamedPkt_i[lane].branchMask[b] &&
                           !(ctrlVerified_i && b == int'(ctrlVerifiedId_i));
      end
      nextIq[lane]             = iqFromGroup(renamedPkt_i[lane], expMask[lane]);
      nextAl[lane].isLoad      = renamedPkt_i[lane].isLoad;
      nextAl[lane].isStore     = renamedPkt_i[lane].isStore;
      nextAl[lane].pc          = renamedPkt_i[lane].pc;
      nextAl[lane].archDest    = renamedPkt_i[lane].archDest;
      nextAl[lane].physDest    = renamedPkt_i[lane].physDest;
      nextAl[lane].oldPhysDest = renamedPkt_i[lane].oldPhysDest;
      nextAl[lane].destValid   = renamedPkt_i[lane].destValid;
      nextLsq[lane].branchMask = expMask[lane];
      nextLsq[lane].isStore    = renamedPkt_i[lane].isStore;
      nextLsq[lane].isLoad     = renamedPkt_i[lane].isLoad;
    end
    expStall = (int'(loadQueueCnt_i) + loads > LsqSize) ||
               (int'(storeQueueCnt_i) + stores > LsqSize) ||
               (int'(issueQueueCnt_i) + DispatchWidth > IssueQSize) ||
               (int'(activeListCnt_i) + DispatchWidth > ActiveListSize);
    expReady = renameReady_i && !expStall && !flagRecover_i;
  end

  // Expected output register, one cycle behind
  always @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      expValid <= 1'b0;
      expIq    <= '0;
      expAl    <= '0;
      expLsq   <= '0;
    end else begin
      expValid <= expReady;
      if (expReady) begin
        expIq  <= nextIq;
        expAl  <= nextAl;
        expLsq <= nextLsq;
      end
    end
  end

  aResetValid: assert property (@(posedge clk)
    (!arstN_i && cycleCnt > 0) |-> !dispatchValid_o && iqPkt_o == '0 &&
                                   alPkt_o == '0 && lsqPkt_o == '0)
    else begin
      errCount++;
      $display("FAILED dispatchValid_o during reset got %h expected 0, or packets not zero",
               $sampled(dispatchValid_o));
    end

  aFirstEdge: assert property (@(posedge clk)
    (cycleCnt > 1 && $rose(arstN_i)) |-> !dispatchValid_o)
    else begin
      errCount++;
      $display("FAILED dispatchValid_o at reset release got %h expected 0",
               $sampled(dispatchValid_o));
    end

  aStall: assert property (@(posedge clk) disable iff (!arstN_i) stallFrontEnd_o == expStall)
    else begin
      errCount++;
      $display("FAILED stallFrontEnd_o got %h expected %h",
               $sampled(stallFrontEnd_o), $sampled(expStall));
    end

  aReady: assert property (@(posedge clk) disable iff (!arstN_i) backEndReady_o == expReady)
    else begin
      errCount++;
      $display("FAILED backEndReady_o got %h expected %h",
               $sampled(backEndReady_o), $sampled(expReady));
    end

  aMask: assert property (@(posedge clk) disable iff (!arstN_i) updatedBranchMask_o == expMask)
    else begin
      errCount++;
      $display("FAILED updatedBranchMask_o got %h expected %h",
               $sampled(updatedBranchMask_o), $sampled(expMask));
    end

  aValid: assert property (@(posedge clk) disable iff (!arstN_i) dispatchValid_o == expValid)
    else begin
      errCount++;
      $display("FAILED dispatchValid_o got %h expected %h",
               $sampled(dispatchValid_o), $sampled(expValid));
    end

  aIq: assert property (@(posedge clk) disable iff (!arstN_i) iqPkt_o == expIq)
    else begin
      errCount++;
      $display("FAILED iqPkt_o got %h expected %h", $sampled(iqPkt_o), $sampled(expIq));
    end

  aAl: assert property (@(posedge clk) disable iff (!arstN_i) alPkt_o == expAl)
    else begin
      errCount++;
      $display("FAILED alPkt_o got %h expected %h", $sampled(alPkt_o), $sampled(expAl));
    end

  aLsq: assert property (@(posedge clk) disable iff (!arstN_i) lsqPkt_o == expLsq)
    else begin
      errCount++;
      $display("FAILED lsqPkt_o got %h expected %h", $sampled(lsqPkt_o), $sampled(expLsq));
    end

  // Refused group leaves the register as it was
  aHold: assert property (@(posedge clk) disable iff (!arstN_i)
    !expReady |=> $stable(iqPkt_o) && $stable(alPkt_o) && $stable(lsqPkt_o))
    else begin
      errCount++;
      $display("Packet outputs changed on an edge where the group was refused");
    end

  task automatic driveGroup(input int ldQ, input int stQ, input int iqQ, input int alQ,
                            input logic ready, input logic recover, input logic verified);
    dispatchPkg::renamedPktT [DispatchWidth-1:0] grp;
    logic [31:0] r;
    @(posedge clk);
    for (int lane = 0; lane < DispatchWidth; lane++) grp[lane] = randomPkt();
    r = nextRand();
    renamedPkt_i     <= grp;
    renameReady_i    <= ready;
    flagRecover_i    <= recover;
    ctrlVerified_i   <= verified;
    ctrlVerifiedId_i <= r[16 +: dispatchPkg::CheckpointIdW];
    loadQueueCnt_i   <= LsqCntW'(ldQ);
    storeQueueCnt_i  <= LsqCntW'(stQ);
    issueQueueCnt_i  <= IqCntW'(iqQ);
    activeListCnt_i  <= AlCntW'(alQ);
  endtask

  task automatic finishTest(input string name, input int startErr);
    repeat (2) @(posedge clk);   // Let the registered checks fire
    #1;
    testsRun++;
    if (errCount == startErr) testsPassed++;
    $display("test %0d %s done, %0d errors", testsRun, name, errCount - startErr);
  endtask

  initial begin
    #(Timeout);
    $display("Watchdog expired before the tests finished");
    $display("sim failed");
    $finish;
  end

  initial begin
    int startErr;
    arstN_i          = 1'b0;
    renamedPkt_i     = '0;
    renameReady_i    = 1'b0;
    flagRecover_i    = 1'b0;
    ctrlVerified_i   = 1'b0;
    ctrlVerifiedId_i = '0;
    loadQueueCnt_i   = '0;
    storeQueueCnt_i  = '0;
    issueQueueCnt_i  = '0;
    activeListCnt_i  = '0;

    startErr = errCount;
    repeat (5) @(posedge clk);
    arstN_i <= 1'b1;
    finishTest("reset", startErr);

    startErr = errCount;
    for (int i = 0; i < 20; i++) begin
      driveGroup(randRange(0, 4), randRange(0, 4), 0, 0, 1'b1, 1'b0, randRange(0, 1) == 1);
    end
    finishTest("packet formation", startErr);

    startErr = errCount;
    for (int i = 0; i < 40; i++) begin
      driveGroup(randRange(LsqSize - DispatchWidth - 1, LsqSize),
                 randRange(LsqSize - DispatchWidth - 1, LsqSize), 0, 0, 1'b1, 1'b0, 1'b0);
    end
    finishTest("load and store space", startErr);

    startErr = errCount;
    for (int i = 0; i < 8; i++) begin   // Sweep each edge, then both near full
      driveGroup(0, 0, IssueQSize - DispatchWidth - 3 + i, 0, 1'b1, 1'b0, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      driveGroup(0, 0, 0, ActiveListSize - DispatchWidth - 3 + i, 1'b1, 1'b0, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      driveGroup(0, 0, randRange(IssueQSize - 7, IssueQSize),
                 randRange(ActiveListSize - 7, ActiveListSize), 1'b1, 1'b0, 1'b0);
    end
    finishTest("issue queue and active list space", startErr);

    startErr = errCount;
    for (int i = 0; i < 30; i++) begin
      driveGroup(0, 0, 0, 0, 1'b1, 1'b0, randRange(0, 1) == 1);
    end
    finishTest("branch mask update", startErr);

    startErr = errCount;
    for (int i = 0; i < 40; i++) begin
      driveGroup(randRange(LsqSize - DispatchWidth, LsqSize), 0, 0, 0,
                 randRange(0, 3) != 0, randRange(0, 2) == 0, randRange(0, 1) == 1);
    end
    finishTest("recovery and hold", startErr);

    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             testsRun, testsPassed, testsRun - testsPassed, errCount);
    if (errCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: list.f
dispatchPkg.sv
dispatchDecode.sv
dispatchCapacity.sv
dispatchResult.sv
dispatch.sv
tbDispatch.sv

// File: Bender.yml
# Four-wide dispatch stage of an out-of-order core

package:
  name: dispatch

sources:
  # Package first, then the stages, then the top level
  - dispatchPkg.sv
  - dispatchDecode.sv
  - dispatchCapacity.sv
  - dispatchResult.sv
  - dispatch.sv

  # Testbench, top module tbDispatch
  - target: simulation
    files:
      - tbDispatch.sv

  - target: test
    files:
      - tbDispatch.sv
